//--- sim.f
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/hazard_ctrl.sv
hdl/operand_muxes.sv
hdl/alu_stage.sv
hdl/pipe_top.sv
test/pipe_tb.sv

//--- Bender.yml
package:
  name: pipe_core

sources:
  - hdl/pipe_pkg.sv
  - hdl/reg_file.sv
  - hdl/hazard_ctrl.sv
  - hdl/operand_muxes.sv
  - hdl/alu_stage.sv
  - hdl/pipe_top.sv
  - target: test
    files:
      - test/pipe_tb.sv

//--- test/pipe_tb.sv
// Testbench for pipe_top with clock, reset, stimulus phases, reference model, scoreboard and watchdog

`timescale 1ns/1ns

module pipe_tb;

	localparam int dw = pipe_pkg::data_width_default;

	// Run length in cycles, sets the watchdog limit
	localparam int num_instr   = 31 + 16 + 20 + 80 + 16 + 30 + 60;
	localparam int stall_limit = 150;
	localparam int margin      = 400;
	localparam int timeout_ns  = (num_instr + stall_limit + margin) * 10;

	logic                clk = 1'b0;
	logic                rst;
	logic                stall;
	pipe_pkg::id_instr_t instr;
	pipe_pkg::result_t   res;

	// Stimulus state
	integer seed = 32'h04b9_b73f;
	int     stall_pct;
	int     stall_left;
	string  test_name;

	// Reference register array and expected results in program order
	logic [dw-1:0]     model_regs [0:31];
	pipe_pkg::result_t exp_q [$];
	int                accepted;
	int                compared;
	int                errors;

	pipe_top pipe_top_inst (
		.clk   (clk),
		.rst   (rst),
		.instr (instr),
		.stall (stall),
		.res   (res)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	////////////////////
	// Helpers
	////////////////////

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic pipe_pkg::alu_op_e rand_op();
		return pipe_pkg::alu_op_e'(3'(rand_range(0, 6)));
	endfunction

	// Stall draws stop once the budget is spent
	function automatic logic pick_stall();
		if (stall_left > 0 && rand_range(0, 99) < stall_pct) begin
			stall_left--;
			return 1'b1;
		end
		return 1'b0;
	endfunction

	// ALU rule, shifts by the low five bits of B
	function automatic logic [dw-1:0] alu_model(input pipe_pkg::alu_op_e op,
		input logic [dw-1:0] a, input logic [dw-1:0] b);
		case (op)
			pipe_pkg::op_add: return a + b;
			pipe_pkg::op_sub: return a - b;
			pipe_pkg::op_and: return a & b;
			pipe_pkg::op_or:  return a | b;
			pipe_pkg::op_xor: return a ^ b;
			pipe_pkg::op_sll: return a << b[4:0];
			pipe_pkg::op_srl: return a >> b[4:0];
			default:          return '0;
		endcase
	endfunction

	// Present one instruction and hold it until an edge with stall low
	task automatic issue(input pipe_pkg::alu_op_e op, input int rd, input int ra, input int rb,
		input logic use_imm, input logic [15:0] simm);
		pipe_pkg::id_instr_t i;
		logic st;
		i.valid   = 1'b1;
		i.op      = op;
		i.rd      = pipe_pkg::reg_idx_width'(rd);
		i.ra      = pipe_pkg::reg_idx_width'(ra);
		i.rb      = pipe_pkg::reg_idx_width'(rb);
		i.use_imm = use_imm;
		i.simm    = simm;
		@(posedge clk);
		st = pick_stall();
		instr <= i;
		stall <= st;
		while (st) begin
			@(posedge clk);
			st = pick_stall();
			stall <= st;
		end
	endtask

	// Register operands with a random opcode
	task automatic issue_reg(input int rd, input int ra, input int rb);
		issue(rand_op(), rd, ra, rb, 1'b0, 16'h0);
	endtask

	// Cycles with no valid instruction, ID freezes while EX takes bubbles
	task automatic bubble(input int n);
		repeat (n) begin
			@(posedge clk);
			instr <= '0;
			stall <= pick_stall();
		end
	endtask

	// Run until every expected result has been consumed
	task automatic drain();
		@(posedge clk);
		instr <= '0;
		stall <= pick_stall();
		@(negedge clk);
		while (exp_q.size() != 0) begin
			@(posedge clk);
			stall <= pick_stall();
			@(negedge clk);
		end
		@(posedge clk);
		stall <= 1'b0;
		// A few idle edges to catch stray results
		repeat (4) @(posedge clk);
	endtask

	////////////////////
	// Model and scoreboard
	////////////////////

	// Check the consumed result first, then model the accepted instruction
	always @(posedge clk) begin : score
		pipe_pkg::result_t head;
		pipe_pkg::result_t exp_res;
		logic [dw-1:0]     op_b;
		if (!rst) begin
			a_no_early_res: assert (!res.valid || accepted != 0) else begin
				errors++;
				$display("error %s: result valid before any instruction was accepted", test_name);
			end
			if (res.valid && !stall) begin
				a_res_expected: assert (exp_q.size() != 0) else begin
					errors++;
					$display("error %s: result consumed with no instruction pending", test_name);
				end
				if (exp_q.size() != 0) begin
					head = exp_q.pop_front();
					compared++;
					a_res_match: assert (res === head) else begin
						errors++;
						$display("error %s: expected rd=%0d data=%h, actual rd=%0d data=%h valid=%b",
							test_name, head.rd, head.data, res.rd, res.data, res.valid);
					end
				end
			end
			if (instr.valid && !stall) begin
				op_b = instr.use_imm ? {{(dw - 16){instr.simm[15]}}, instr.simm}
					: model_regs[instr.rb];
				exp_res.valid = 1'b1;
				exp_res.rd    = instr.rd;
				exp_res.data  = alu_model(instr.op, model_regs[instr.ra], op_b);
				// Register 0 stays zero
				if (instr.rd != '0) begin
					model_regs[instr.rd] = exp_res.data;
				end
				exp_q.push_back(exp_res);
				accepted++;
			end
		end
	end

	// Stalled pipeline keeps its result record
	a_hold_on_stall: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(res))
	else begin
		errors++;
		$display("error %s: res changed while stall was high", test_name);
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin : stimulus
		int prev;
		int rx;
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		rst        = 1'b1;
		stall      = 1'b0;
		instr      = '0;
		stall_pct  = 0;
		stall_left = stall_limit;
		accepted   = 0;
		compared   = 0;
		errors     = 0;
		test_name  = "reset";
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// Known value in every register through the immediate path
		test_name = "init";
		for (int r = 1; r < 32; r++) begin
			issue(pipe_pkg::op_add, r, 0, 0, 1'b1, 16'(rand_range(0, 65535)));
		end

		// Every opcode, sources never written in flight
		test_name = "rf_ops";
		for (int k = 0; k < 14; k++) begin
			issue(pipe_pkg::alu_op_e'(3'(k % 7)), rand_range(16, 31), rand_range(1, 15),
				rand_range(1, 15), 1'b0, 16'h0);
		end
		// r0 write shows up in res, later read still gives zero
		issue(pipe_pkg::op_add, 0, 1, 2, 1'b0, 16'h0);
		issue(pipe_pkg::op_or, 20, 0, 0, 1'b0, 16'h0);

		// Back-to-back chain through the EX path
		test_name = "ex_fwd";
		prev = 1;
		for (int k = 0; k < 20; k++) begin
			rx = rand_range(1, 31);
			issue_reg(rx, prev, (k % 2 == 1) ? prev : rand_range(1, 31));
			prev = rx;
		end

		// Producers use 1..10, fillers write 20..31 and read 11..19
		test_name = "wb_fwd";
		for (int k = 0; k < 8; k++) begin
			rx = rand_range(1, 10);
			issue_reg(rx, rand_range(11, 19), rand_range(11, 19));
			issue_reg(rand_range(20, 31), rand_range(11, 19), rand_range(11, 19));
			issue_reg(rand_range(20, 31), rx, rand_range(11, 19));
			// Distance three reads the written register file
			issue_reg(rx, rand_range(11, 19), rand_range(11, 19));
			issue_reg(rand_range(20, 31), rand_range(11, 19), rand_range(11, 19));
			issue_reg(rand_range(20, 31), rand_range(11, 19), rand_range(11, 19));
			issue_reg(rand_range(20, 31), rand_range(11, 19), rx);
			// EX and WB both hold rx, younger EX value wins
			issue_reg(rx, rand_range(11, 19), rand_range(11, 19));
			issue_reg(rx, rand_range(11, 19), rand_range(11, 19));
			issue_reg(rand_range(20, 31), rx, rx);
		end

		// Immediate B with A forwarded, every other one negative
		test_name = "imm";
		for (int k = 0; k < 16; k++) begin
			rx = rand_range(1, 31);
			issue(rand_op(), rx, prev, 0, 1'b1, {k[0], 15'(rand_range(0, 32767))});
			prev = rx;
		end

		test_name = "gaps";
		for (int k = 0; k < 30; k++) begin
			bubble(rand_range(0, 3));
			rx = rand_range(1, 31);
			issue_reg(rx, prev, rand_range(1, 31));
			prev = rx;
		end

		// Random back-pressure on top of gaps and dependencies
		test_name = "stalls";
		stall_pct = 30;
		for (int k = 0; k < 60; k++) begin
			bubble(rand_range(0, 2));
			rx = rand_range(0, 31);
			if (k % 3 == 0) begin
				issue(rand_op(), rx, prev, 0, 1'b1, 16'(rand_range(0, 65535)));
			end else begin
				issue_reg(rx, prev, rand_range(0, 31));
			end
			prev = rx;
		end
		drain();

		a_queue_empty: assert (exp_q.size() == 0) else begin
			errors++;
			$display("%0d expected results were never consumed", exp_q.size());
		end
		$display("Results compared: %0d, errors: %0d", compared, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Ends a run that stops making progress
	initial begin : watchdog
		#(timeout_ns);
		$display("Timeout after %0d ns, results compared: %0d, errors: %0d",
			timeout_ns, compared, errors);
		$display("Test failed");
		$finish;
	end

endmodule

//--- hdl/pipe_top.sv
// Top level wiring register file, hazard control, operand muxes and ALU stage

`timescale 1ns/1ns

module pipe_top #(
	parameter int width = pipe_pkg::data_width_default
) (
	input  logic                clk,
	input  logic                rst,
	input  pipe_pkg::id_instr_t instr,
	input  logic                stall,
	output pipe_pkg::result_t   res
);

	// Result record carries data at the default width
	if (width != pipe_pkg::data_width_default) begin : g_width_check
		$error("pipe_top width must equal the result record data width");
	end

	////////////////////
	// Internal wires
	////////////////////

	// Selects and freezes
	pipe_pkg::sel_e    sel_a;
	pipe_pkg::sel_e    sel_b;
	logic              id_freeze;
	logic              ex_freeze;

	// In-flight destinations
	pipe_pkg::dst_t    ex_dst;
	pipe_pkg::dst_t    wb_dst;

	// Datapath
	logic [width-1:0]  rf_dataa;
	logic [width-1:0]  rf_datab;
	logic [width-1:0]  operand_a;
	logic [width-1:0]  operand_b;
	logic [width-1:0]  ex_forw;
	logic [width-1:0]  wb_forw;
	pipe_pkg::result_t wb_res;

	// WB destination seen by hazard control
	assign wb_dst.valid = wb_res.valid;
	assign wb_dst.rd    = wb_res.rd;

	// Retired result goes straight out
	assign res = wb_res;

	////////////////////
	// Instances
	////////////////////

	// Write happens as the WB record is consumed
	reg_file #(
		.width(width)
	) reg_file_inst (
		.clk      (clk),
		.rst      (rst),
		.ra       (instr.ra),
		.rb       (instr.rb),
		.wr       (wb_res),
		.we_en    (!ex_freeze),
		.rf_dataa (rf_dataa),
		.rf_datab (rf_datab)
	);

	hazard_ctrl hazard_ctrl_inst (
		.instr     (instr),
		.stall     (stall),
		.ex_dst    (ex_dst),
		.wb_dst    (wb_dst),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze)
	);

	operand_muxes #(
		.width(width)
	) operand_muxes_inst (
		.clk       (clk),
		.rst       (rst),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_dataa  (rf_dataa),
		.rf_datab  (rf_datab),
		.ex_forw   (ex_forw),
		.wb_forw   (wb_forw),
		.simm      (instr.simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	alu_stage #(
		.width(width)
	) alu_stage_inst (
		.clk       (clk),
		.rst       (rst),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.instr     (instr),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_dst    (ex_dst),
		.ex_forw   (ex_forw),
		.wb_res    (wb_res),
		.wb_forw   (wb_forw)
	);

endmodule

//--- hdl/alu_stage.sv
// EX control register, ALU and WB result register feeding both forwarding paths

`timescale 1ns/1ns

module alu_stage #(
	parameter int width = pipe_pkg::data_width_default
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                id_freeze,
	input  logic                ex_freeze,
	input  pipe_pkg::id_instr_t instr,
	input  logic [width-1:0]    operand_a,
	input  logic [width-1:0]    operand_b,
	output pipe_pkg::dst_t      ex_dst,
	output logic [width-1:0]    ex_forw,
	output pipe_pkg::result_t   wb_res,
	output logic [width-1:0]    wb_forw
);

	pipe_pkg::alu_op_e ex_op;
	logic [4:0]        shamt;

	////////////////////
	// EX control register
	////////////////////

	// Loads in step with the operand registers
	// A frozen ID sends a bubble into EX
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_dst.valid <= 1'b0;
		end else if (!ex_freeze) begin
			ex_dst.valid <= instr.valid && !id_freeze;
			ex_dst.rd    <= instr.rd;
			ex_op        <= instr.op;
		end
	end

	////////////////////
	// ALU
	////////////////////

	// Shift amount from the low bits of B
	assign shamt = operand_b[4:0];

	// Combinational result, also the EX forwarding path
	always_comb begin
		case (ex_op)
			pipe_pkg::op_add: ex_forw = operand_a + operand_b;
			pipe_pkg::op_sub: ex_forw = operand_a - operand_b;
			pipe_pkg::op_and: ex_forw = operand_a & operand_b;
			pipe_pkg::op_or:  ex_forw = operand_a | operand_b;
			pipe_pkg::op_xor: ex_forw = operand_a ^ operand_b;
			pipe_pkg::op_sll: ex_forw = operand_a << shamt;
			pipe_pkg::op_srl: ex_forw = operand_a >> shamt;
			default:          ex_forw = '0;
		endcase
	end

	////////////////////
	// WB result register
	////////////////////

	// Holds under stall so the consumer sees a stable record
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_res.valid <= 1'b0;
		end else if (!ex_freeze) begin
			wb_res.valid <= ex_dst.valid;
			wb_res.rd    <= ex_dst.rd;
			wb_res.data  <= pipe_pkg::data_width_default'(ex_forw);
		end
	end

	// WB forwarding path, the registered data at operand width
	assign wb_forw = wb_res.data[width-1:0];

endmodule

//--- hdl/operand_muxes.sv
// Operand A and B source muxes with sign-extended immediate and save-once operand registers

`timescale 1ns/1ns

module operand_muxes #(
	parameter int width = pipe_pkg::data_width_default
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             id_freeze,
	input  logic             ex_freeze,
	input  logic [width-1:0] rf_dataa,
	input  logic [width-1:0] rf_datab,
	input  logic [width-1:0] ex_forw,
	input  logic [width-1:0] wb_forw,
	input  logic [15:0]      simm,
	input  pipe_pkg::sel_e   sel_a,
	input  pipe_pkg::sel_e   sel_b,
	output logic [width-1:0] operand_a,
	output logic [width-1:0] operand_b
);

	logic [width-1:0] muxed_a;
	logic [width-1:0] muxed_b;
	logic [width-1:0] simm_ext;
	logic             saved_a;
	logic             saved_b;

	// Immediate sign-extended to the operand width
	assign simm_ext = width'($signed(simm));

	////////////////////
	// Source muxes
	////////////////////

	// Operand A, register file unless forwarded
	always_comb begin
		case (sel_a)
			pipe_pkg::sel_ex_forw: muxed_a = ex_forw;
			pipe_pkg::sel_wb_forw: muxed_a = wb_forw;
			default:               muxed_a = rf_dataa;
		endcase
	end

	// Operand B, may also take the immediate
	always_comb begin
		case (sel_b)
			pipe_pkg::sel_imm:     muxed_b = simm_ext;
			pipe_pkg::sel_ex_forw: muxed_b = ex_forw;
			pipe_pkg::sel_wb_forw: muxed_b = wb_forw;
			default:               muxed_b = rf_datab;
		endcase
	end

	////////////////////
	// Operand registers
	////////////////////

	// Running ID loads every edge
	// Frozen ID captures once and then holds while forwarding moves on
	always_ff @(posedge clk) begin
		if (rst) begin
			operand_a <= '0;
			saved_a   <= 1'b0;
		end else if (!ex_freeze) begin
			if (!id_freeze) begin
				operand_a <= muxed_a;
				saved_a   <= 1'b0;
			end else if (!saved_a) begin
				operand_a <= muxed_a;
				saved_a   <= 1'b1;
			end
		end
	end

	// Same rule for B
	always_ff @(posedge clk) begin
		if (rst) begin
			operand_b <= '0;
			saved_b   <= 1'b0;
		end else if (!ex_freeze) begin
			if (!id_freeze) begin
				operand_b <= muxed_b;
				saved_b   <= 1'b0;
			end else if (!saved_b) begin
				operand_b <= muxed_b;
				saved_b   <= 1'b1;
			end
		end
	end

	////////////////////
	// Checks
	////////////////////

	// Immediate belongs to B only
	a_no_imm_on_a: assert property (@(posedge clk) disable iff (rst)
		sel_a != pipe_pkg::sel_imm);

	// Forwarded EX value lands in operand A one edge later
	a_fwd_ex_a: assert property (@(posedge clk) disable iff (rst)
		(!ex_freeze && !id_freeze && sel_a == pipe_pkg::sel_ex_forw)
		|=> operand_a == $past(ex_forw));

	// Forwarded WB value lands in operand B one edge later
	a_fwd_wb_b: assert property (@(posedge clk) disable iff (rst)
		(!ex_freeze && !id_freeze && sel_b == pipe_pkg::sel_wb_forw)
		|=> operand_b == $past(wb_forw));

endmodule

//--- hdl/hazard_ctrl.sv
// Forwarding source selection for both operands and derivation of the ID and EX freezes

`timescale 1ns/1ns

module hazard_ctrl (
	input  pipe_pkg::id_instr_t instr,
	input  logic                stall,
	input  pipe_pkg::dst_t      ex_dst,
	input  pipe_pkg::dst_t      wb_dst,
	output pipe_pkg::sel_e      sel_a,
	output pipe_pkg::sel_e      sel_b,
	output logic                id_freeze,
	output logic                ex_freeze
);

	// Source select for one register index
	// Register 0 never forwards because the register file gives zero
	// EX holds the younger value so it wins over WB
	function automatic pipe_pkg::sel_e src_sel(
		input logic [pipe_pkg::reg_idx_width-1:0] src,
		input pipe_pkg::dst_t                     ex_d,
		input pipe_pkg::dst_t                     wb_d
	);
		pipe_pkg::sel_e sel;
		sel = pipe_pkg::sel_rf;
		if (src != '0) begin
			if (ex_d.valid && (ex_d.rd == src)) begin
				sel = pipe_pkg::sel_ex_forw;
			end else if (wb_d.valid && (wb_d.rd == src)) begin
				sel = pipe_pkg::sel_wb_forw;
			end
		end
		return sel;
	endfunction

	////////////////////
	// Operand selects
	////////////////////

	assign sel_a = src_sel(instr.ra, ex_dst, wb_dst);

	// Immediate replaces B whatever the dependencies
	assign sel_b = instr.use_imm ? pipe_pkg::sel_imm : src_sel(instr.rb, ex_dst, wb_dst);

	////////////////////
	// Freezes
	////////////////////

	// Consumer back-pressure holds the whole pipeline
	assign ex_freeze = stall;

	// No valid instruction in ID means EX takes a bubble
	assign id_freeze = stall || !instr.valid;

endmodule

//--- hdl/reg_file.sv
// Register file with two combinational read ports, one write port and register 0 held at zero

`timescale 1ns/1ns

module reg_file #(
	parameter int width = pipe_pkg::data_width_default
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic [pipe_pkg::reg_idx_width-1:0] ra,
	input  logic [pipe_pkg::reg_idx_width-1:0] rb,
	input  pipe_pkg::result_t                  wr,
	input  logic                               we_en,
	output logic [width-1:0]                   rf_dataa,
	output logic [width-1:0]                   rf_datab
);

	// Storage for all 32 registers
	// Entry 0 is cleared by reset and never written afterwards
	logic [width-1:0] regs [0:(1 << pipe_pkg::reg_idx_width)-1];

	////////////////////
	// Write port
	////////////////////

	// Write only when the WB stage moves on
	// A write to register 0 is dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			regs[0] <= '0;
		end else if (wr.valid && we_en && (wr.rd != '0)) begin
			regs[wr.rd] <= wr.data[width-1:0];
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// No bypass of the write since the WB forwarding path covers it
	assign rf_dataa = regs[ra];
	assign rf_datab = regs[rb];

	// Register 0 reads zero even after a retired write to it
	a_r0_zero: assert property (@(posedge clk) disable iff (rst)
		(ra != '0 || rf_dataa == '0) && (rb != '0 || rf_datab == '0));

endmodule

//--- hdl/pipe_pkg.sv
// Shared widths, ALU opcode and operand source enums, instruction, destination and result structs

package pipe_pkg;

	////////////////////
	// Widths
	////////////////////

	// Default operand width, the top level passes it down as width
	localparam int data_width_default = 32;

	// Register index width, fixed by the instruction format
	localparam int reg_idx_width = 5;

	////////////////////
	// Enums
	////////////////////

	// ALU opcodes
	// Shifts take the shift amount from the low five bits of B
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		op_sll = 3'd5,
		op_srl = 3'd6
	} alu_op_e;

	// Operand source select
	// sel_imm is legal for operand B only
	typedef enum logic [1:0] {
		sel_rf      = 2'd0,
		sel_imm     = 2'd1,
		sel_ex_forw = 2'd2,
		sel_wb_forw = 2'd3
	} sel_e;

	////////////////////
	// Records
	////////////////////

	// Decoded ALU instruction entering ID
	typedef struct packed {
		logic                     valid;
		alu_op_e                  op;
		logic [reg_idx_width-1:0] rd;
		logic [reg_idx_width-1:0] ra;
		logic [reg_idx_width-1:0] rb;
		logic                     use_imm;
		logic [15:0]              simm;
	} id_instr_t;

	// Destination of an instruction still in flight
	typedef struct packed {
		logic                     valid;
		logic [reg_idx_width-1:0] rd;
	} dst_t;

	// Retired result, doubles as the register file write port
	typedef struct packed {
		logic                          valid;
		logic [reg_idx_width-1:0]      rd;
		logic [data_width_default-1:0] data;
	} result_t;

endpackage
